//--- Bender.yml
package:
  name: umi_fifo_flex

sources:
  - target: rtl
    files:
      - design/umi_cmd_pkg.sv
      - design/umi_flex_cfg_pkg.sv
      - design/umi_splitter.sv
      - design/umi_sync_fifo.sv
      - design/umi_fifo_flex.sv
  - target: test
    files:
      - verification/tb_umi_checks.sv
      - verification/tb_umi_fifo_flex.sv

//--- design/umi_cmd_pkg.sv
package umi_cmd_pkg;

   // ####################################################################
   // UMI command word
   // ####################################################################

   localparam int CW = 32;

   typedef logic [CW-1:0] cmd_t;

   // Command fields
   typedef logic [4:0] opcode_t;
   typedef logic [2:0] size_t;
   typedef logic [7:0] len_t;

   // ####################################################################
   // Field positions inside cmd_t
   // ####################################################################

   // Opcode occupies bits 4:0
   localparam int OPCODE_LSB = 0;

   // SIZE is log2 of the bytes per word, bits 7:5
   localparam int SIZE_LSB = 5;

   // LEN counts words minus one, bits 15:8
   localparam int LEN_LSB = 8;

   // End of message marker
   localparam int EOM_BIT = 22;

endpackage

//--- design/umi_fifo_flex.sv
module umi_fifo_flex
   import umi_flex_cfg_pkg::*;
(
   input  logic      umi_in_clk,
   input  logic      umi_in_nreset,
   input  logic      bypass,
   input  logic      umi_in_valid,
   input  in_beat_t  umi_in_beat,
   output logic      umi_in_ready,
   output logic      umi_out_valid,
   output out_beat_t umi_out_beat,
   input  logic      umi_out_ready,
   output logic      fifo_full,
   output logic      fifo_empty
);

   // Splitter to FIFO link
   logic      split_valid;
   logic      split_ready;
   out_beat_t split_beat;

   // FIFO side
   logic      fifo_wr;
   logic      fifo_rd;
   logic      fifo_full_raw;
   logic      fifo_empty_raw;
   out_beat_t fifo_beat;

   // ####################################################################
   // Width split
   // ####################################################################

   // Downstream is the sink in bypass, the FIFO otherwise
   assign split_ready = bypass ? umi_out_ready : ~fifo_full_raw;

   umi_splitter u_splitter (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (umi_in_valid),
      .in_beat       (umi_in_beat),
      .in_ready      (umi_in_ready),
      .out_valid     (split_valid),
      .out_beat      (split_beat),
      .out_ready     (split_ready)
   );

   // ####################################################################
   // Beat storage
   // ####################################################################

   // FIFO stays idle and empty while bypassed
   assign fifo_wr = split_valid & ~bypass;
   assign fifo_rd = umi_out_ready & ~bypass;

   umi_sync_fifo u_fifo (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .wr_en         (fifo_wr),
      .wr_beat       (split_beat),
      .rd_en         (fifo_rd),
      .full          (fifo_full_raw),
      .empty         (fifo_empty_raw),
      .rd_beat       (fifo_beat)
   );

   // Output selection
   assign umi_out_valid = bypass ? split_valid : ~fifo_empty_raw;
   assign umi_out_beat  = bypass ? split_beat  : fifo_beat;
   assign fifo_full     = bypass ? ~umi_out_ready : fifo_full_raw;
   assign fifo_empty    = bypass ? 1'b1 : fifo_empty_raw;

endmodule

//--- design/umi_flex_cfg_pkg.sv
package umi_flex_cfg_pkg;

   import umi_cmd_pkg::*;

   // ####################################################################
   // Bus widths
   // ####################################################################

   localparam int AW  = 64;
   localparam int IDW = 256;
   localparam int ODW = 64;

   // Bytes carried by one output beat
   localparam int OUT_BYTES = ODW / 8;

   // Storage, depth must be a power of two for pointer wrap
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = 2;

   typedef logic [AW-1:0]  addr_t;
   typedef logic [IDW-1:0] in_data_t;
   typedef logic [ODW-1:0] out_data_t;

   // ####################################################################
   // Beats on each side of the converter
   // ####################################################################

   typedef struct packed {
      cmd_t     cmd;
      addr_t    dstaddr;
      addr_t    srcaddr;
      in_data_t data;
   } in_beat_t;

   typedef struct packed {
      cmd_t      cmd;
      addr_t     dstaddr;
      addr_t     srcaddr;
      out_data_t data;
   } out_beat_t;

endpackage

//--- design/umi_splitter.sv
module umi_splitter
   import umi_cmd_pkg::*;
   import umi_flex_cfg_pkg::*;
(
   input  logic      umi_in_clk,
   input  logic      umi_in_nreset,
   input  logic      in_valid,
   input  in_beat_t  in_beat,
   output logic      in_ready,
   output logic      out_valid,
   output out_beat_t out_beat,
   input  logic      out_ready
);

   // Remainder of a transaction that is still being split
   logic        rem_valid;
   cmd_t        rem_cmd;
   addr_t       rem_dstaddr;
   addr_t       rem_srcaddr;
   in_data_t    rem_data;

   // Beat presented on the output this cycle
   cmd_t        cur_cmd;
   addr_t       cur_dstaddr;
   addr_t       cur_srcaddr;
   in_data_t    cur_data;
   size_t       cur_size;
   len_t        cur_len;

   logic [15:0] byte_cnt;
   len_t        beat_len;
   len_t        rem_len_next;
   cmd_t        rem_cmd_next;
   logic        need_split;
   logic        beat_done;

   // ####################################################################
   // Source selection
   // ####################################################################

   // A held remainder always goes out before new input
   always_comb
   begin
      if (rem_valid)
      begin
         cur_cmd     = rem_cmd;
         cur_dstaddr = rem_dstaddr;
         cur_srcaddr = rem_srcaddr;
         cur_data    = rem_data;
      end
      else
      begin
         cur_cmd     = in_beat.cmd;
         cur_dstaddr = in_beat.dstaddr;
         cur_srcaddr = in_beat.srcaddr;
         cur_data    = in_beat.data;
      end
   end

   assign cur_size = cur_cmd[SIZE_LSB +: $bits(size_t)];
   assign cur_len  = cur_cmd[LEN_LSB +: $bits(len_t)];

   // ####################################################################
   // Size arithmetic
   // ####################################################################

   // Bytes left in the transaction, (LEN+1) << SIZE
   assign byte_cnt   = ({8'b0, cur_len} + 16'd1) << cur_size;
   assign need_split = (byte_cnt > 16'(OUT_BYTES));

   // Words in a full output beat, minus one
   assign beat_len = len_t'((OUT_BYTES >> cur_size) - 1);

   // LEN still owed after this beat
   assign rem_len_next = cur_len - beat_len - 8'd1;

   always_comb
   begin
      rem_cmd_next = cur_cmd;
      rem_cmd_next[LEN_LSB +: $bits(len_t)] = rem_len_next;
   end

   // ####################################################################
   // Output beat
   // ####################################################################

   always_comb
   begin
      out_beat.cmd = cur_cmd;
      // Only the last beat keeps the input EOM
      if (need_split)
      begin
         out_beat.cmd[LEN_LSB +: $bits(len_t)] = beat_len;
         out_beat.cmd[EOM_BIT]                 = 1'b0;
      end
      out_beat.dstaddr = cur_dstaddr;
      out_beat.srcaddr = cur_srcaddr;
      out_beat.data    = cur_data[ODW-1:0];
   end

   assign out_valid = in_valid | rem_valid;
   assign in_ready  = ~rem_valid & out_ready;
   assign beat_done = out_valid & out_ready;

   // ####################################################################
   // Remainder register
   // ####################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_valid <= 1'b0;
      else if (beat_done)
         rem_valid <= need_split;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (beat_done && need_split)
      begin
         rem_cmd     <= rem_cmd_next;
         rem_dstaddr <= cur_dstaddr + addr_t'(OUT_BYTES);
         rem_srcaddr <= cur_srcaddr + addr_t'(OUT_BYTES);
         rem_data    <= cur_data >> ODW;
      end
   end

endmodule

//--- design/umi_sync_fifo.sv
module umi_sync_fifo
   import umi_flex_cfg_pkg::*;
(
   input  logic      umi_in_clk,
   input  logic      umi_in_nreset,
   input  logic      wr_en,
   input  out_beat_t wr_beat,
   input  logic      rd_en,
   output logic      full,
   output logic      empty,
   output out_beat_t rd_beat
);

   out_beat_t             mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // ####################################################################
   // Flags and qualified strobes
   // ####################################################################

   assign full  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
   assign empty = (count == '0);

   // Overflow and underflow are dropped here
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // ####################################################################
   // Pointers and occupancy
   // ####################################################################

   // Pointers wrap on their own width
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ####################################################################
   // Storage
   // ####################################################################

   always_ff @(posedge umi_in_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_beat;
   end

   // Head entry is visible as soon as it is written
   assign rd_beat = mem[rd_ptr];

endmodule

//--- flist.f
design/umi_cmd_pkg.sv
design/umi_flex_cfg_pkg.sv
design/umi_splitter.sv
design/umi_sync_fifo.sv
design/umi_fifo_flex.sv
verification/tb_umi_checks.sv
verification/tb_umi_fifo_flex.sv

//--- verification/tb_umi_checks.sv
module tb_umi_checks
   import umi_cmd_pkg::*;
   import umi_flex_cfg_pkg::*;
(
   input  logic      umi_in_clk,
   input  logic      umi_in_nreset,
   input  logic      bypass,
   input  logic      umi_in_valid,
   input  in_beat_t  umi_in_beat,
   input  logic      umi_in_ready,
   input  logic      umi_out_valid,
   input  out_beat_t umi_out_beat,
   input  logic      umi_out_ready,
   input  logic      fifo_full,
   input  logic      fifo_empty,
   output logic      check_fail,
   output int        pending
);

   timeunit 1ns;
   timeprecision 1ps;

   out_beat_t exp_q [$];
   out_beat_t q_head;
   out_beat_t exp_head;
   int        split_left;
   int        fill;
   logic      down_ready;
   logic      in_accept;
   logic      exp_out_valid;
   logic      out_xfer;

   function automatic int beat_total(input in_beat_t b);
      int bytes;
      bytes = (int'(b.cmd[LEN_LSB +: $bits(len_t)]) + 1) << b.cmd[SIZE_LSB +: $bits(size_t)];
      return (bytes + OUT_BYTES - 1) / OUT_BYTES;
   endfunction

   // Beat k of a wide transaction
   function automatic out_beat_t beat_slice(input in_beat_t b, input int k);
      out_beat_t o;
      int        len;
      int        words;
      len   = int'(b.cmd[LEN_LSB +: $bits(len_t)]);
      words = OUT_BYTES >> b.cmd[SIZE_LSB +: $bits(size_t)];
      o.cmd = b.cmd;
      if (k == beat_total(b) - 1)
         o.cmd[LEN_LSB +: $bits(len_t)] = len_t'(len - k * words);
      else
      begin
         o.cmd[LEN_LSB +: $bits(len_t)] = len_t'(words - 1);
         o.cmd[EOM_BIT]                 = 1'b0;
      end
      o.dstaddr = b.dstaddr + addr_t'(k * OUT_BYTES);
      o.srcaddr = b.srcaddr + addr_t'(k * OUT_BYTES);
      o.data    = out_data_t'(b.data >> (k * ODW));
      return o;
   endfunction

   // ####################################################################
   // Reference model
   // ####################################################################

   assign down_ready    = bypass ? umi_out_ready : (fill != FIFO_DEPTH);
   assign in_accept     = umi_in_valid && (split_left == 0) && down_ready;
   assign exp_out_valid = bypass ? (umi_in_valid || split_left != 0) : (fill != 0);
   assign out_xfer      = exp_out_valid && umi_out_ready;
   // In bypass the first beat leaves in the cycle of its acceptance
   assign exp_head      = (pending != 0) ? q_head : beat_slice(umi_in_beat, 0);

   always @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         exp_q.delete();
         pending    <= 0;
         q_head     <= '0;
         split_left <= 0;
         fill       <= 0;
      end
      else
      begin
         if (in_accept)
            for (int k = 0; k < beat_total(umi_in_beat); k++)
               exp_q.push_back(beat_slice(umi_in_beat, k));
         if (out_xfer && exp_q.size() != 0)
            void'(exp_q.pop_front());
         pending <= exp_q.size();
         if (exp_q.size() != 0)
            q_head <= exp_q[0];
         // Beats still held back in the splitter
         if (in_accept)
            split_left <= beat_total(umi_in_beat) - 1;
         else if (split_left != 0 && down_ready)
            split_left <= split_left - 1;
         if (!bypass)
            fill <= fill + int'((umi_in_valid || split_left != 0) && down_ready)
                         - int'(out_xfer);
      end
   end

   initial check_fail = 1'b0;

   task automatic report_value(input string name, input logic [$bits(out_beat_t)-1:0] exp_val,
                               input logic [$bits(out_beat_t)-1:0] act_val);
      $display("[ERROR] time %0d ns %s expected %0h actual %0h", $time, name, exp_val, act_val);
      check_fail = 1'b1;
   endtask

   task automatic report_failure(input string what);
      $display("[ERROR] time %0d ns %s", $time, what);
      check_fail = 1'b1;
   endtask

   // ####################################################################
   // Checks
   // ####################################################################

   // First edge after reset release
   a_reset_idle: assert property (@(posedge umi_in_clk)
      $rose(umi_in_nreset) |-> !umi_out_valid && fifo_empty && !fifo_full && umi_in_ready)
      else report_failure("outputs are not idle after reset release");

   a_beat: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_out_valid && umi_out_ready |-> umi_out_beat == exp_head)
      else report_value("umi_out_beat", $sampled(exp_head), $sampled(umi_out_beat));

   a_in_ready: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_in_ready == ((split_left == 0) && down_ready))
      else report_value("umi_in_ready", $sampled((split_left == 0) && down_ready),
                        $sampled(umi_in_ready));

   a_out_valid: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_out_valid == exp_out_valid)
      else report_value("umi_out_valid", $sampled(exp_out_valid), $sampled(umi_out_valid));

   a_flags: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      {fifo_full, fifo_empty} == {bypass ? !umi_out_ready : fill == FIFO_DEPTH,
                                  bypass || fill == 0})
      else report_value("{fifo_full, fifo_empty}",
                        $sampled({bypass ? !umi_out_ready : fill == FIFO_DEPTH,
                                  bypass || fill == 0}),
                        $sampled({fifo_full, fifo_empty}));

   // Stalled output holds its payload
   a_hold: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      umi_out_valid && !umi_out_ready |=> $stable(umi_out_beat))
      else report_failure("umi_out_beat changed while the sink was stalled");

endmodule

//--- verification/tb_umi_fifo_flex.sv
module tb_umi_fifo_flex
   import umi_cmd_pkg::*;
   import umi_flex_cfg_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_TXN          = 60;
   localparam int TIMEOUT_CYCLES = N_TXN * 32 * 4;

   logic      umi_in_clk;
   logic      umi_in_nreset;
   logic      bypass;
   logic      umi_in_valid;
   in_beat_t  umi_in_beat;
   logic      umi_in_ready;
   logic      umi_out_valid;
   out_beat_t umi_out_beat;
   logic      umi_out_ready;
   logic      fifo_full;
   logic      fifo_empty;
   logic      check_fail;
   int        pending;

   integer    seed = 32'h72f8;
   int        hold_cycles;
   logic      random_ready;
   int        cycle_cnt;

   umi_fifo_flex u_dut (.*);

   tb_umi_checks u_checks (.*);

   always #20 umi_in_clk = ~umi_in_clk;

   // Byte count above lo_bytes and at most hi_bytes
   task automatic build_txn(input int lo_bytes, input int hi_bytes, output in_beat_t b);
      size_t size;
      int    lo_len;
      int    span;
      b.cmd  = $random(seed);
      size   = size_t'($unsigned($random(seed)) % 4);
      lo_len = lo_bytes >> size;
      span   = (hi_bytes >> size) - lo_len;
      b.cmd[SIZE_LSB +: $bits(size_t)] = size;
      b.cmd[LEN_LSB +: $bits(len_t)]   = len_t'(lo_len + $unsigned($random(seed)) % span);
      b.dstaddr = {$random(seed), $random(seed)};
      b.srcaddr = {$random(seed), $random(seed)};
      for (int i = 0; i < IDW / 32; i++)
         b.data[i*32 +: 32] = $random(seed);
   endtask

   // Called at a rising edge, returns at the edge of the handshake
   task automatic send_txn(input in_beat_t b);
      logic taken;
      #2;
      umi_in_beat  = b;
      umi_in_valid = 1'b1;
      taken        = 1'b0;
      while (!taken)
      begin
         @(negedge umi_in_clk);
         taken = umi_in_ready;
         @(posedge umi_in_clk);
      end
   endtask

   task automatic run_phase(input int count, input int lo_bytes, input int hi_bytes);
      in_beat_t b;
      for (int i = 0; i < count; i++)
      begin
         build_txn(lo_bytes, hi_bytes, b);
         send_txn(b);
      end
      #2;
      umi_in_valid = 1'b0;
      do
         @(negedge umi_in_clk);
      while (pending != 0);
      @(posedge umi_in_clk);
   endtask

   always @(posedge umi_in_clk)
   begin
      #2;
      if (hold_cycles != 0)
      begin
         umi_out_ready = 1'b0;
         hold_cycles   = hold_cycles - 1;
      end
      else
         umi_out_ready = random_ready ? 1'($random(seed)) : 1'b1;
   end

   always @(posedge umi_in_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: transactions did not complete in %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   always @(posedge check_fail)
   begin
      $display("TEST FAILED");
      $fatal(1, "Run stopped at the first failed check");
   end

   initial
   begin
      umi_in_clk    = 1'b0;
      umi_in_nreset = 1'b0;
      bypass        = 1'b0;
      umi_in_valid  = 1'b0;
      umi_in_beat   = '0;
      umi_out_ready = 1'b1;
      hold_cycles   = 0;
      random_ready  = 1'b0;
      cycle_cnt     = 0;
      repeat (16) @(posedge umi_in_clk);
      #2;
      umi_in_nreset = 1'b1;
      @(posedge umi_in_clk);
      // Single beats, then splits, sink always ready
      run_phase(N_TXN / 4, 0, 8);
      run_phase(N_TXN / 4, 8, 32);
      // Stalled sink fills the FIFO, random ready afterwards
      hold_cycles  = 24;
      random_ready = 1'b1;
      run_phase(N_TXN / 4, 0, 32);
      #2;
      bypass = 1'b1;
      @(posedge umi_in_clk);
      run_phase(N_TXN / 4, 0, 32);
      // Checks of the last edge settle first
      @(negedge umi_in_clk);
      if (!check_fail && pending == 0)
      begin
         $display("TEST OK");
         $finish;
      end
      else
      begin
         $display("TEST FAILED");
         $fatal(1, "Run ended with failed checks or beats left over");
      end
   end

endmodule
